/* verilog/stall_pkg.sv */
// Stall injector definitions: operating modes, the configuration word
// and the width of a stall count. Shared by the stall blocks and the
// testbench that programs them.

package stall_pkg;

    // Stall count width, covers 0 to 255 cycles
    localparam int STALL_CNT_W = 8;

    // Operating mode, selects how the configuration word is read
    typedef enum logic [1:0] {
        STALL_OFF    = 2'd0,
        STALL_FIXED  = 2'd1,
        STALL_RANDOM = 2'd2
    } stall_mode_e;

    // Fixed mode, separate counts for grant and response
    typedef struct packed {
        logic [STALL_CNT_W-1:0] grant_stalls;
        logic [STALL_CNT_W-1:0] resp_stalls;
    } stall_fixed_t;

    // Random mode, one upper bound for both paths
    typedef struct packed {
        logic [STALL_CNT_W-1:0] max_stall;
        logic [STALL_CNT_W-1:0] reserved;
    } stall_random_t;

    // One 16-bit word, decoded by mode
    typedef union packed {
        stall_fixed_t  fixed;
        stall_random_t random;
    } stall_cfg_u;

endpackage

/* verilog/mem_bus_pkg.sv */
// Memory port field widths for the request/grant/response bus.
// The top level takes its width defaults from here and the
// testbench uses the same byte enable type.

package mem_bus_pkg;

    // Byte enables, one per byte of a 32-bit word
    localparam int BE_W = 4;

    typedef logic [BE_W-1:0] be_t;

    // Default bus widths handed down by the top level
    localparam int ADDR_W_DEF = 32;
    localparam int DATA_W_DEF = 32;

endpackage

/* verilog/stall_timer.sv */
// Loadable down-counter used to time one stall at a time.
// done_o is high while the count is zero; loading zero gives done at once.
// The owner must only load again after it has seen done.

`timescale 1ns/1ns

module stall_timer #(
    parameter int STALL_CNT_W = stall_pkg::STALL_CNT_W
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   load_i,
    input  logic [STALL_CNT_W-1:0] value_i,
    output logic                   done_o
);

    logic [STALL_CNT_W-1:0] cnt_q;

    // Load N gives done N cycles later, so store N-1
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= (value_i == '0) ? '0 : value_i - 1'b1;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // Bypass on load so a zero count finishes in the load cycle
    assign done_o = load_i ? (value_i == '0) : (cnt_q == '0);

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // A running stall is never cut short by a new load
    a_no_reload: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        load_i |-> (cnt_q == '0)
    );

endmodule

/* verilog/stall_lfsr.sv */
// Pseudo-random stall count source. A 16-bit Galois LFSR steps once per
// draw and its low byte is bounded to 0..max_i. The count is valid
// combinationally in the cycle of the draw.

`timescale 1ns/1ns

module stall_lfsr #(
    parameter logic [15:0] LFSR_SEED = 16'hACE1
) (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                draw_i,
    input  logic [stall_pkg::STALL_CNT_W-1:0]   max_i,
    output logic [stall_pkg::STALL_CNT_W-1:0]   count_o
);

    logic [15:0]                         lfsr_q;
    logic [stall_pkg::STALL_CNT_W-1:0]   mask;
    logic [stall_pkg::STALL_CNT_W-1:0]   masked;

    // Galois step, taps 16,14,13,11; an all-zero seed would lock up
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lfsr_q <= (LFSR_SEED == 16'h0000) ? 16'h0001 : LFSR_SEED;
        end else if (draw_i) begin
            lfsr_q <= {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? 16'hB400 : 16'h0000);
        end
    end

    always_comb begin
        // Smear max_i right to get the smallest all-ones cover
        mask = max_i | (max_i >> 1);
        mask = mask | (mask >> 2);
        mask = mask | (mask >> 4);
        masked = lfsr_q[stall_pkg::STALL_CNT_W-1:0] & mask;
        // mask <= 2*max+1, so one fold lands in range
        count_o = (masked > max_i) ? masked - max_i - 1'b1 : masked;
    end

    // Bounded draw, the random mode relies on it on both paths
    a_count_bound: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        draw_i |-> (count_o <= max_i)
    );

endmodule

/* verilog/grant_stall_fsm.sv */
// Grant path of the stall injector. Holds a core request back by the
// mode-decoded stall count, then forwards it to memory until granted.
// Also tracks granted transactions not yet answered to the core.

`timescale 1ns/1ns

module grant_stall_fsm #(
    parameter int          OUTSTANDING_DEPTH = 4,
    parameter logic [15:0] LFSR_SEED         = 16'hACE1,
    localparam int         PEND_W            = $clog2(OUTSTANDING_DEPTH + 1)
) (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    req_core_i,
    input  logic                    gnt_mem_i,
    input  stall_pkg::stall_mode_e  mode_i,
    input  stall_pkg::stall_cfg_u   cfg_i,
    input  logic                    full_i,
    input  logic                    rvalid_core_i,
    output logic                    req_mem_o,
    output logic                    gnt_core_o,
    output logic [PEND_W-1:0]       pending_o
);

    typedef enum logic [1:0] {IDLE, STALL, FORWARD} state_e;

    state_e                             state_q, state_d;
    logic [stall_pkg::STALL_CNT_W-1:0]  stall_cnt, draw_cnt;
    logic                               timer_load, timer_done, fwd_en;
    logic [PEND_W-1:0]                  pend_q;

    // Stall count for the request being accepted
    always_comb begin
        case (mode_i)
            stall_pkg::STALL_FIXED:  stall_cnt = cfg_i.fixed.grant_stalls;
            stall_pkg::STALL_RANDOM: stall_cnt = draw_cnt;
            default:                 stall_cnt = '0;
        endcase
    end

    assign timer_load = (state_q == IDLE) && req_core_i;
    // Forward on the cycle the stall runs out, zero stall included
    assign fwd_en = !full_i && ((state_q == FORWARD) ||
                    ((state_q == STALL || timer_load) && timer_done));
    assign req_mem_o  = fwd_en;
    assign gnt_core_o = fwd_en && gnt_mem_i;
    assign pending_o  = pend_q;

    stall_timer #(.STALL_CNT_W(stall_pkg::STALL_CNT_W)) u_timer (
        .clk_i, .arst_n_i, .load_i(timer_load), .value_i(stall_cnt), .done_o(timer_done)
    );

    stall_lfsr #(.LFSR_SEED(LFSR_SEED)) u_lfsr (
        .clk_i, .arst_n_i, .draw_i(timer_load && (mode_i == stall_pkg::STALL_RANDOM)),
        .max_i(cfg_i.random.max_stall), .count_o(draw_cnt)
    );

    always_comb begin
        state_d = state_q;
        if (state_q == IDLE && req_core_i) begin
            state_d = timer_done ? FORWARD : STALL;
        end else if (state_q == STALL && timer_done) begin
            state_d = FORWARD;
        end
        // Granted, ready for the next request
        if (fwd_en && gnt_mem_i) begin
            state_d = IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            pend_q  <= '0;
        end else begin
            state_q <= state_d;
            pend_q  <= pend_q + PEND_W'(gnt_core_o) - PEND_W'(rvalid_core_i);
        end
    end

    // Memory never grants a request that is not on the bus
    a_gnt_with_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        gnt_mem_i |-> req_mem_o);
    // Full from the top keeps the count within depth
    a_pend_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pend_q <= PEND_W'(OUTSTANDING_DEPTH));

endmodule

/* verilog/resp_delay_fifo.sv */
// Response path of the stall injector. Memory responses queue in order;
// each new head waits for its stall count before it goes to the core.
// Depth matches the outstanding limit, so it is never pushed when full.

`timescale 1ns/1ns

module resp_delay_fifo #(
    parameter int          DATA_WIDTH        = 32,
    parameter int          OUTSTANDING_DEPTH = 4,
    parameter logic [15:0] LFSR_SEED         = 16'h1D2B,
    localparam int         PTR_W = (OUTSTANDING_DEPTH > 1) ? $clog2(OUTSTANDING_DEPTH) : 1
) (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    rvalid_mem_i,
    input  logic [DATA_WIDTH-1:0]   rdata_mem_i,
    input  stall_pkg::stall_mode_e  mode_i,
    input  stall_pkg::stall_cfg_u   cfg_i,
    output logic                    rvalid_core_o,
    output logic [DATA_WIDTH-1:0]   rdata_core_o
);

    logic [DATA_WIDTH-1:0]              data_q [OUTSTANDING_DEPTH];
    logic [PTR_W-1:0]                   wr_ptr_q, rd_ptr_q;
    logic [PTR_W:0]                     count_q;
    logic                               head_armed_q, head_valid;
    logic                               timer_load, timer_done, pop;
    logic [stall_pkg::STALL_CNT_W-1:0]  stall_cnt, draw_cnt;

    // Head timer is armed once per entry
    assign head_valid = (count_q != '0);
    assign timer_load = head_valid && !head_armed_q;
    assign pop        = head_valid && timer_done;

    always_comb begin
        case (mode_i)
            stall_pkg::STALL_FIXED:  stall_cnt = cfg_i.fixed.resp_stalls;
            stall_pkg::STALL_RANDOM: stall_cnt = draw_cnt;
            default:                 stall_cnt = '0;
        endcase
    end

    stall_timer #(.STALL_CNT_W(stall_pkg::STALL_CNT_W)) u_timer (
        .clk_i, .arst_n_i, .load_i(timer_load), .value_i(stall_cnt), .done_o(timer_done)
    );

    // Draw at head load only
    stall_lfsr #(.LFSR_SEED(LFSR_SEED)) u_lfsr (
        .clk_i, .arst_n_i, .draw_i(timer_load && (mode_i == stall_pkg::STALL_RANDOM)),
        .max_i(cfg_i.random.max_stall), .count_o(draw_cnt)
    );

    //////////////////////////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rvalid_mem_i) begin
            data_q[wr_ptr_q] <= rdata_mem_i;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            count_q      <= '0;
            head_armed_q <= 1'b0;
        end else begin
            wr_ptr_q <= wr_ptr_q + PTR_W'(rvalid_mem_i);
            rd_ptr_q <= rd_ptr_q + PTR_W'(pop);
            count_q  <= count_q + (PTR_W + 1)'(rvalid_mem_i) - (PTR_W + 1)'(pop);
            if (pop) begin
                head_armed_q <= 1'b0;
            end else if (timer_load) begin
                head_armed_q <= 1'b1;
            end
        end
    end

    assign rvalid_core_o = pop;
    assign rdata_core_o  = data_q[rd_ptr_q];

    // Outstanding limit upstream keeps room for every response
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rvalid_mem_i |-> (count_q != (PTR_W + 1)'(OUTSTANDING_DEPTH)));

endmodule

/* verilog/mem_stall_top.sv */
// Stall injector between a core memory port and the memory.
// Request fields pass straight through; only the grant and the
// response valid are delayed. Configuration comes in on ports.

`timescale 1ns/1ns

module mem_stall_top #(
    parameter int          ADDR_WIDTH        = mem_bus_pkg::ADDR_W_DEF,
    parameter int          DATA_WIDTH        = mem_bus_pkg::DATA_W_DEF,
    parameter int          OUTSTANDING_DEPTH = 4,
    parameter logic [15:0] LFSR_SEED         = 16'hACE1
) (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    // Core side
    input  logic                    req_core_i,
    input  logic [ADDR_WIDTH-1:0]   addr_core_i,
    input  logic                    we_core_i,
    input  mem_bus_pkg::be_t        be_core_i,
    input  logic [DATA_WIDTH-1:0]   wdata_core_i,
    output logic                    gnt_core_o,
    output logic                    rvalid_core_o,
    output logic [DATA_WIDTH-1:0]   rdata_core_o,
    // Memory side
    output logic                    req_mem_o,
    output logic [ADDR_WIDTH-1:0]   addr_mem_o,
    output logic                    we_mem_o,
    output mem_bus_pkg::be_t        be_mem_o,
    output logic [DATA_WIDTH-1:0]   wdata_mem_o,
    input  logic                    gnt_mem_i,
    input  logic                    rvalid_mem_i,
    input  logic [DATA_WIDTH-1:0]   rdata_mem_i,
    // Configuration
    input  stall_pkg::stall_mode_e  stall_mode_i,
    input  stall_pkg::stall_cfg_u   stall_cfg_i
);

    localparam int PEND_W = $clog2(OUTSTANDING_DEPTH + 1);

    logic [PEND_W-1:0] pending;
    logic              out_full;

    // Request payload is not touched
    assign addr_mem_o  = addr_core_i;
    assign we_mem_o    = we_core_i;
    assign be_mem_o    = be_core_i;
    assign wdata_mem_o = wdata_core_i;

    // No new grant once every FIFO slot may be claimed
    assign out_full = (pending == PEND_W'(OUTSTANDING_DEPTH));

    grant_stall_fsm #(.OUTSTANDING_DEPTH(OUTSTANDING_DEPTH), .LFSR_SEED(LFSR_SEED)) u_gnt (
        .clk_i, .arst_n_i, .req_core_i, .gnt_mem_i, .mode_i(stall_mode_i), .cfg_i(stall_cfg_i),
        .full_i(out_full), .rvalid_core_i(rvalid_core_o), .req_mem_o, .gnt_core_o,
        .pending_o(pending)
    );

    // Second LFSR runs on its own seed
    resp_delay_fifo #(.DATA_WIDTH(DATA_WIDTH), .OUTSTANDING_DEPTH(OUTSTANDING_DEPTH),
                      .LFSR_SEED(LFSR_SEED ^ 16'h5A5A)) u_resp (
        .clk_i, .arst_n_i, .rvalid_mem_i, .rdata_mem_i, .mode_i(stall_mode_i),
        .cfg_i(stall_cfg_i), .rvalid_core_o, .rdata_core_o
    );

endmodule

/* testbench/tb_mem_model.sv */
// Memory model for the stall injector testbench. Grants at once or after
// a delay given on gnt_dly_i, and answers 1 to 3 cycles after each grant,
// in order, with the granted address inverted as read data.

`timescale 1ns/1ns

module tb_mem_model #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  req_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  logic                  imm_i,
    input  logic [1:0]            gnt_dly_i,
    input  logic [1:0]            rsp_dly_i,
    output logic                  gnt_o,
    output logic                  rvalid_o,
    output logic [DATA_WIDTH-1:0] rdata_o
);

    logic [1:0]            wait_q;
    longint                cyc_q;
    longint                last_due;
    longint                due_q[$];
    logic [DATA_WIDTH-1:0] data_q[$];

    // Grant comes straight from the request once the wait has run out
    assign gnt_o = req_i && (imm_i || wait_q == 2'd0);

    always @(posedge clk_i or negedge arst_n_i) begin
        longint due;
        if (!arst_n_i) begin
            wait_q   <= 2'd0;
            rvalid_o <= 1'b0;
            rdata_o  <= '0;
            cyc_q    = 0;
            last_due = 0;
            due_q.delete();
            data_q.delete();
        end else begin
            // Next grant delay is taken at each grant
            if (gnt_o) begin
                wait_q <= gnt_dly_i;
            end else if (req_i && wait_q != 2'd0) begin
                wait_q <= wait_q - 2'd1;
            end
            // Queue the answer, never two in one cycle
            if (gnt_o) begin
                due = cyc_q + longint'(rsp_dly_i);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                due_q.push_back(due);
                data_q.push_back(DATA_WIDTH'(~addr_i));
            end
            rvalid_o <= 1'b0;
            if (due_q.size() > 0 && due_q[0] == cyc_q + 1) begin
                rvalid_o <= 1'b1;
                rdata_o  <= data_q.pop_front();
                void'(due_q.pop_front());
            end
            cyc_q = cyc_q + 1;
        end
    end

endmodule

/* testbench/tb_mem_stall.sv */
// Testbench for the memory stall injector. Drives the core port through
// passthrough, fixed, random and back-pressure phases against a memory
// model; concurrent assertions check grant timing, response timing,
// ordering and the outstanding limit. Ends with a pass or fail line.

`timescale 1ns/1ns

module tb_mem_stall;

    localparam int DEPTH     = 4;
    localparam int GNT_N     = 3;
    localparam int RSP_M     = 2;
    localparam int RAND_K    = 5;
    localparam int TXN_TOTAL = 62;
    localparam int WORST_CYC = 40;
    localparam longint TIMEOUT_NS = longint'(TXN_TOTAL * WORST_CYC + 200) * 10;

    logic clk_i = 1'b0;
    logic arst_n_i;
    logic req_core_i, we_core_i, gnt_core_o, rvalid_core_o;
    logic [31:0] addr_core_i, wdata_core_i, rdata_core_o;
    mem_bus_pkg::be_t be_core_i, be_mem_o;
    logic req_mem_o, we_mem_o, gnt_mem_i, rvalid_mem_i;
    logic [31:0] addr_mem_o, wdata_mem_o, rdata_mem_i;
    stall_pkg::stall_mode_e mode;
    stall_pkg::stall_cfg_u  cfg;
    logic imm, single;
    logic [1:0] gnt_dly, rsp_dly;
    logic [15:0] lfsr_q = 16'd46484;
    int age, since_rsp, wr_idx, rd_idx;
    logic [31:0] addr_log [1024];
    logic chk_off, chk_fix, chk_rand;

    // 10 ns clock
    always #5 clk_i = ~clk_i;

    mem_stall_top #(.ADDR_WIDTH(32), .DATA_WIDTH(32), .OUTSTANDING_DEPTH(DEPTH)) dut (
        .clk_i, .arst_n_i, .req_core_i, .addr_core_i, .we_core_i, .be_core_i,
        .wdata_core_i, .gnt_core_o, .rvalid_core_o, .rdata_core_o, .req_mem_o,
        .addr_mem_o, .we_mem_o, .be_mem_o, .wdata_mem_o, .gnt_mem_i, .rvalid_mem_i,
        .rdata_mem_i, .stall_mode_i(mode), .stall_cfg_i(cfg)
    );

    tb_mem_model #(.ADDR_WIDTH(32), .DATA_WIDTH(32)) u_mem (
        .clk_i, .arst_n_i, .req_i(req_mem_o), .addr_i(addr_mem_o), .imm_i(imm),
        .gnt_dly_i(gnt_dly), .rsp_dly_i(rsp_dly), .gnt_o(gnt_mem_i),
        .rvalid_o(rvalid_mem_i), .rdata_o(rdata_mem_i)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    task automatic stop_on_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    // Memory latency choices drawn on each falling edge
    always @(negedge clk_i) begin
        logic [31:0] v;
        draw_bits(2, v);
        gnt_dly <= v[1:0];
        draw_bits(2, v);
        rsp_dly <= (v[1:0] == 2'd0) ? 2'd1 : v[1:0];
    end

    //////////////////////////////////////////////////////////////////////
    // Reference tracking
    //////////////////////////////////////////////////////////////////////

    // Cycles the current request has waited and cycles since a memory response
    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            age       <= 0;
            since_rsp <= 0;
            wr_idx    <= 0;
            rd_idx    <= 0;
        end else begin
            age       <= (!req_core_i || gnt_core_o) ? 0 : age + 1;
            since_rsp <= rvalid_mem_i ? 1 : since_rsp + 1;
            if (gnt_core_o) begin
                addr_log[wr_idx % 1024] <= addr_core_i;
                wr_idx <= wr_idx + 1;
            end
            if (rvalid_core_o) begin
                rd_idx <= rd_idx + 1;
            end
        end
    end

    assign chk_off  = single && imm && mode == stall_pkg::STALL_OFF;
    assign chk_fix  = single && imm && mode == stall_pkg::STALL_FIXED;
    assign chk_rand = single && imm && mode == stall_pkg::STALL_RANDOM;

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    a_off_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        chk_off && req_core_i |-> gnt_core_o)
        else stop_on_error("grant not immediate with stalling off");
    a_fields: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_mem_o |-> (addr_mem_o == addr_core_i && we_mem_o == we_core_i &&
                       be_mem_o == be_core_i && wdata_mem_o == wdata_core_i))
        else stop_on_error("request fields changed on the way to memory");
    a_fix_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        chk_fix && req_core_i && age < GNT_N |-> !req_mem_o && !gnt_core_o)
        else stop_on_error("request forwarded before the grant stall ran out");
    a_fix_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        chk_fix && req_core_i && age == GNT_N |-> req_mem_o && gnt_core_o)
        else stop_on_error("grant missing when the grant stall ran out");
    a_fix_rsp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        chk_fix && rvalid_core_o |-> since_rsp == RSP_M + 1)
        else stop_on_error("response stall length wrong");
    a_order: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rvalid_core_o |-> (rd_idx < wr_idx && rdata_core_o == ~addr_log[rd_idx % 1024]))
        else stop_on_error("response out of order or with wrong data");
    a_rand: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        chk_rand && req_core_i |-> age <= RAND_K)
        else stop_on_error("random grant stall above max_stall");
    a_depth: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wr_idx - rd_idx <= DEPTH)
        else stop_on_error("outstanding transactions above depth");
    a_reset: assert property (@(posedge clk_i)
        !arst_n_i |-> !req_mem_o && !gnt_core_o && !rvalid_core_o)
        else stop_on_error("outputs active during reset");

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // Present one request and hold it until granted
    task automatic issue();
        logic [31:0] v;
        @(posedge clk_i);
        draw_bits(30, v);
        addr_core_i <= {v[29:0], 2'b00};
        draw_bits(1, v);
        we_core_i <= v[0];
        draw_bits(4, v);
        be_core_i <= v[3:0];
        draw_bits(32, v);
        wdata_core_i <= v;
        req_core_i <= 1'b1;
        do begin
            @(negedge clk_i);
        end while (!gnt_core_o);
    endtask

    task automatic drop_req();
        @(posedge clk_i);
        req_core_i <= 1'b0;
    endtask

    task automatic wait_drain();
        while (rd_idx != wr_idx) begin
            @(negedge clk_i);
        end
    endtask

    task automatic single_txns(input int n);
        for (int i = 0; i < n; i++) begin
            issue();
            drop_req();
            wait_drain();
        end
    endtask

    initial begin
        arst_n_i = 1'b0;
        req_core_i = 1'b0;
        addr_core_i = '0;
        we_core_i = 1'b0;
        be_core_i = '0;
        wdata_core_i = '0;
        mode = stall_pkg::STALL_OFF;
        cfg = '0;
        imm = 1'b1;
        single = 1'b1;
        repeat (4) @(posedge clk_i);
        arst_n_i <= 1'b1;
        single_txns(6);
        // Fixed grant and response stalls
        @(posedge clk_i);
        mode <= stall_pkg::STALL_FIXED;
        cfg.fixed.grant_stalls <= 8'(GNT_N);
        cfg.fixed.resp_stalls <= 8'(RSP_M);
        single_txns(6);
        @(posedge clk_i);
        mode <= stall_pkg::STALL_RANDOM;
        cfg.random.max_stall <= 8'(RAND_K);
        cfg.random.reserved <= 8'd0;
        single_txns(10);
        // Back-to-back traffic, slow memory, long response stalls
        @(posedge clk_i);
        single <= 1'b0;
        imm <= 1'b0;
        mode <= stall_pkg::STALL_FIXED;
        cfg.fixed.grant_stalls <= 8'd0;
        cfg.fixed.resp_stalls <= 8'd6;
        for (int i = 0; i < 30; i++) begin
            issue();
        end
        drop_req();
        wait_drain();
        // Reset with traffic in flight
        for (int i = 0; i < 8; i++) begin
            issue();
        end
        @(posedge clk_i);
        req_core_i <= 1'b0;
        arst_n_i <= 1'b0;
        repeat (4) @(posedge clk_i);
        arst_n_i <= 1'b1;
        single_txns(1);
        issue();
        drop_req();
        // Last response gets a bounded time to come back
        for (int i = 0; i < WORST_CYC && rd_idx != wr_idx; i++) begin
            @(negedge clk_i);
        end
        repeat (10) @(posedge clk_i);
        if (rd_idx != wr_idx) begin
            stop_on_error("response count does not match grant count");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

    // Watchdog sized from transaction count and worst case per transaction
    initial begin
        #(TIMEOUT_NS);
        $display("Simulation timed out before all transactions finished");
        $display("Regression failed");
        $fatal(1);
    end

endmodule

/* vlog.f */
verilog/stall_pkg.sv
verilog/mem_bus_pkg.sv
verilog/stall_timer.sv
verilog/stall_lfsr.sv
verilog/grant_stall_fsm.sv
verilog/resp_delay_fifo.sv
verilog/mem_stall_top.sv
testbench/tb_mem_model.sv
testbench/tb_mem_stall.sv

/* Makefile */
# Verilator build and run of the stall injector testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_stall
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
